/* Bender.yml */
package:
  name: gpio_deglitch

sources:
  # packages first, the RTL uses them in port lists
  - common/dg_cfg_pkg.sv
  - common/dg_evt_pkg.sv
  # RTL
  - src/channel_sampler.sv
  - deglitch/deglitch_chan.sv
  - deglitch/deglitch_bank.sv
  - src/edge_event_capture.sv
  - src/gpio_deglitch_top.sv
  # testbench
  - target: test
    files:
      - testbench/tb_gpio_deglitch.sv

/* common/dg_cfg_pkg.sv */
// ==================================================
// deglitcher configuration
// ==================================================

package dg_cfg_pkg;

    // number of input channels
    // packed structs below and in dg_evt_pkg are sized by this
    localparam int CH_NUM = 8;

    // ==================================================
    // runtime configuration, static while running
    // ==================================================

    // one bit per channel in every field
    // bit i of each field belongs to channel i
    typedef struct packed {
        // flip the filtered level before it leaves the bank
        logic [CH_NUM-1:0] invert;
        // allow a rising filtered edge to raise an event
        logic [CH_NUM-1:0] rise_en;
        // allow a falling filtered edge to raise an event
        logic [CH_NUM-1:0] fall_en;
    } dg_cfg_t;

    // edges are seen after the invert stage,
    // so rise_en refers to the level as seen at o_level

endpackage : dg_cfg_pkg

/* common/dg_evt_pkg.sv */
// ==================================================
// sample and event types
// ==================================================

package dg_evt_pkg;

    // one sample strobe plus the synchronized levels
    // data only meaningful while vld is high
    typedef struct packed {
        logic                            vld;
        logic [dg_cfg_pkg::CH_NUM-1:0]   data;
    } dg_sample_t;

    // ==================================================
    // filter state per channel
    // ==================================================

    // stable: filtered level equals last accepted value
    // qualify: a new value is being counted
    typedef enum logic {
        FILT_STABLE  = 1'b0,
        FILT_QUALIFY = 1'b1
    } dg_filt_state_e;

    // ==================================================
    // edge events
    // ==================================================

    // kind of a filtered level change
    typedef enum logic [1:0] {
        EDGE_NONE = 2'd0,
        EDGE_RISE = 2'd1,
        EDGE_FALL = 2'd2
    } dg_edge_e;

    // per-channel event strobe, one cycle wide
    // kind is EDGE_NONE wherever hit is low
    typedef struct packed {
        logic     [dg_cfg_pkg::CH_NUM-1:0] hit;
        dg_edge_e [dg_cfg_pkg::CH_NUM-1:0] kind;
    } dg_event_t;

endpackage : dg_evt_pkg

/* deglitch/deglitch_bank.sv */
`timescale 1ns/1ps

// all channel filters plus the polarity register
module deglitch_bank #(
    parameter int unsigned CNT_W = 6,
    parameter int unsigned UP_TH = 3
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  dg_evt_pkg::dg_sample_t        i_sample,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_invert,
    output logic [dg_cfg_pkg::CH_NUM-1:0] o_level
);

    import dg_cfg_pkg::*;

    // raw filter outputs, before polarity
    logic [CH_NUM-1:0] filt_level;

    // ==================================================
    // per-channel filters
    // ==================================================

    // one strobe shared by every channel
    for (genvar ch = 0; ch < CH_NUM; ch++) begin : g_chan
        deglitch_chan #(
            .CNT_W (CNT_W),
            .UP_TH (UP_TH)
        ) u_chan (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_vld   (i_sample.vld),
            .i_data  (i_sample.data[ch]),
            .o_level (filt_level[ch])
        );
    end

    // ==================================================
    // polarity stage
    // ==================================================

    // invert change shows one cycle later
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_level <= '0;
        end else begin
            o_level <= filt_level ^ i_invert;
        end
    end

endmodule : deglitch_bank

/* deglitch/deglitch_chan.sv */
`timescale 1ns/1ps

// persistence filter for a single channel
module deglitch_chan #(
    parameter int unsigned CNT_W = 6,
    parameter int unsigned UP_TH = 3
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_vld,
    input  logic i_data,
    output logic o_level
);

    import dg_evt_pkg::*;

    // ==================================================
    // declarations
    // ==================================================

    logic             last_vld;
    logic             last_data;
    logic [CNT_W-1:0] cnt;
    dg_filt_state_e   state;
    logic             level_q;

    logic             same;
    logic             differ;
    logic             accept;

    // ==================================================
    // sample compare
    // ==================================================

    // nothing is compared until a first sample is stored
    assign same   = i_vld & last_vld & (i_data == last_data);
    assign differ = i_vld & last_vld & (i_data != last_data);

    // held long enough, take the value
    assign accept = same & (state == FILT_QUALIFY) & (cnt >= CNT_W'(UP_TH));

    // previous valid sample
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_vld  <= 1'b0;
            last_data <= 1'b0;
        end else if (i_vld) begin
            last_vld  <= 1'b1;
            last_data <= i_data;
        end
    end

    // ==================================================
    // state and persistence counter
    // ==================================================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= FILT_STABLE;
            cnt   <= '0;
        end else if (differ) begin
            // any change (re)starts qualification
            state <= FILT_QUALIFY;
            cnt   <= CNT_W'(1);
        end else if (accept) begin
            state <= FILT_STABLE;
            cnt   <= '0;
        end else if (same && (state == FILT_QUALIFY)) begin
            cnt   <= cnt + CNT_W'(1);
        end
    end

    // filtered level, one cycle after the accepting strobe
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            level_q <= 1'b0;
        end else if (accept) begin
            level_q <= i_data;
        end
    end

    assign o_level = level_q;

endmodule : deglitch_chan

/* gpio_deglitch_top.f */
common/dg_cfg_pkg.sv
common/dg_evt_pkg.sv
src/channel_sampler.sv
deglitch/deglitch_chan.sv
deglitch/deglitch_bank.sv
src/edge_event_capture.sv
src/gpio_deglitch_top.sv
testbench/tb_gpio_deglitch.sv

/* src/channel_sampler.sv */
`timescale 1ns/1ps

// synchronizer for all pins plus the shared sample strobe
module channel_sampler #(
    parameter int unsigned SAMPLE_DIV = 4
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_pins,
    output dg_evt_pkg::dg_sample_t        o_sample
);

    import dg_cfg_pkg::*;

    // counter width, at least one bit even for SAMPLE_DIV of 1
    localparam int unsigned DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    // ==================================================
    // two-flop synchronizer
    // ==================================================

    logic [CH_NUM-1:0] sync_q1;
    logic [CH_NUM-1:0] sync_q2;

    // first stage may go metastable
    // second stage is the one used downstream
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= i_pins;
            sync_q2 <= sync_q1;
        end
    end

    // ==================================================
    // sample-strobe prescaler
    // ==================================================

    logic [DIV_W-1:0] div_cnt;
    logic             div_wrap;
    logic             vld_q;

    // last count of the period
    assign div_wrap = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

    // free running from reset, modulo SAMPLE_DIV
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
        end else if (div_wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // registered strobe
    // first one SAMPLE_DIV cycles after reset release
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= div_wrap;
        end
    end

    // levels go along with the strobe, no extra stage
    assign o_sample.vld  = vld_q;
    assign o_sample.data = sync_q2;

endmodule : channel_sampler

/* src/edge_event_capture.sv */
`timescale 1ns/1ps

// edge events, sticky pending bits and interrupt
module edge_event_capture (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_level,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_rise_en,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_fall_en,
    input  logic                          i_clr,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_clr_mask,
    output dg_evt_pkg::dg_event_t         o_event,
    output logic [dg_cfg_pkg::CH_NUM-1:0] o_pending,
    output logic                          o_irq
);

    import dg_cfg_pkg::*;
    import dg_evt_pkg::*;

    logic [CH_NUM-1:0] level_q;
    logic [CH_NUM-1:0] rise;
    logic [CH_NUM-1:0] fall;
    dg_event_t         event_d;
    dg_event_t         event_q;
    logic [CH_NUM-1:0] pending_q;
    logic [CH_NUM-1:0] clr_bits;

    // ==================================================
    // edge detect
    // ==================================================

    // previous filtered level
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            level_q <= '0;
        end else begin
            level_q <= i_level;
        end
    end

    // gated by the per-edge enables
    assign rise = i_level & ~level_q & i_rise_en;
    assign fall = ~i_level & level_q & i_fall_en;

    always_comb begin
        event_d.hit = rise | fall;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            if (rise[ch]) begin
                event_d.kind[ch] = EDGE_RISE;
            end else if (fall[ch]) begin
                event_d.kind[ch] = EDGE_FALL;
            end else begin
                event_d.kind[ch] = EDGE_NONE;
            end
        end
    end

    // ==================================================
    // event strobe and pending bits
    // ==================================================

    // only selected bits, only while the strobe is up
    assign clr_bits = i_clr_mask & {CH_NUM{i_clr}};

    // a new hit wins over a clear on the same bit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            event_q   <= '0;
            pending_q <= '0;
        end else begin
            event_q   <= event_d;
            pending_q <= (pending_q & ~clr_bits) | event_d.hit;
        end
    end

    assign o_event   = event_q;
    assign o_pending = pending_q;
    assign o_irq     = |pending_q;

endmodule : edge_event_capture

/* src/gpio_deglitch_top.sv */
`timescale 1ns/1ps

// multi-channel input deglitcher
// pins -> sync/prescale -> filters -> polarity -> edge events
module gpio_deglitch_top #(
    parameter int unsigned CNT_W      = 6,
    parameter int unsigned UP_TH      = 3,
    parameter int unsigned SAMPLE_DIV = 4
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_pins,
    input  dg_cfg_pkg::dg_cfg_t           i_cfg,
    input  logic                          i_clr,
    input  logic [dg_cfg_pkg::CH_NUM-1:0] i_clr_mask,
    output logic [dg_cfg_pkg::CH_NUM-1:0] o_level,
    output dg_evt_pkg::dg_event_t         o_event,
    output logic [dg_cfg_pkg::CH_NUM-1:0] o_pending,
    output logic                          o_irq
);

    import dg_evt_pkg::*;

    // strobe plus synchronized pins
    dg_sample_t sample;

    // ==================================================
    // synchronizer and sample strobe
    // ==================================================

    channel_sampler #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_sampler (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_pins   (i_pins),
        .o_sample (sample)
    );

    // ==================================================
    // filters and polarity
    // ==================================================

    deglitch_bank #(
        .CNT_W (CNT_W),
        .UP_TH (UP_TH)
    ) u_bank (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_sample (sample),
        .i_invert (i_cfg.invert),
        .o_level  (o_level)
    );

    // ==================================================
    // edge events and interrupt
    // ==================================================

    // edges taken from the level after inversion
    edge_event_capture u_capture (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_level    (o_level),
        .i_rise_en  (i_cfg.rise_en),
        .i_fall_en  (i_cfg.fall_en),
        .i_clr      (i_clr),
        .i_clr_mask (i_clr_mask),
        .o_event    (o_event),
        .o_pending  (o_pending),
        .o_irq      (o_irq)
    );

endmodule : gpio_deglitch_top

/* testbench/tb_gpio_deglitch.sv */
`timescale 1ns/1ps

module tb_gpio_deglitch;

    import dg_cfg_pkg::*;
    import dg_evt_pkg::*;

    localparam int unsigned CNT_W         = 6;
    localparam int unsigned UP_TH         = 3;
    localparam int unsigned SAMPLE_DIV    = 4;
    localparam int unsigned RESET_CYCLES  = 10;
    localparam int unsigned MARGIN_CYCLES = 50;

    // one table row holds stimulus and the expected values after the hold
    typedef struct packed {
        logic [CH_NUM-1:0] pins;
        logic [7:0]        hold;
        logic              glitch;
        logic [CH_NUM-1:0] invert;
        logic [CH_NUM-1:0] rise_en;
        logic [CH_NUM-1:0] fall_en;
        logic              clr;
        logic [CH_NUM-1:0] clr_mask;
        logic [CH_NUM-1:0] exp_level;
        logic [CH_NUM-1:0] exp_pending;
        logic              exp_irq;
        logic [15:0]       exp_events;
        logic [15:0]       exp_rises;
    } row_t;

    logic              i_clk = 1'b0;
    logic              i_rst_n;
    logic [CH_NUM-1:0] i_pins;
    dg_cfg_t           i_cfg;
    logic              i_clr;
    logic [CH_NUM-1:0] i_clr_mask;
    logic [CH_NUM-1:0] o_level;
    dg_event_t         o_event;
    logic [CH_NUM-1:0] o_pending;
    logic              o_irq;

    row_t        rows[$];
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 0;
    int unsigned evt_count   = 0;
    int unsigned rise_count  = 0;
    int          cur_row     = -1;

    // reference filter state with one bit per channel
    // m_qual high stands for FILT_QUALIFY and low for FILT_STABLE
    logic [CH_NUM-1:0] m_last;
    logic [CH_NUM-1:0] m_filt;
    logic [CH_NUM-1:0] m_qual;
    logic              m_have;
    int unsigned       m_cnt[CH_NUM];

    gpio_deglitch_top #(
        .CNT_W      (CNT_W),
        .UP_TH      (UP_TH),
        .SAMPLE_DIV (SAMPLE_DIV)
    ) UUT (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pins     (i_pins),
        .i_cfg      (i_cfg),
        .i_clr      (i_clr),
        .i_clr_mask (i_clr_mask),
        .o_level    (o_level),
        .o_event    (o_event),
        .o_pending  (o_pending),
        .o_irq      (o_irq)
    );

    // 20 ns period
    always #10 i_clk = ~i_clk;

    // event monitor samples on the falling edge
    // kind must be EDGE_NONE wherever hit is low
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            for (int ch = 0; ch < CH_NUM; ch++) begin
                if (!o_event.hit[ch]) begin
                    check_value("o_event.kind", 32'(EDGE_NONE), 32'(o_event.kind[ch]));
                end else if (o_event.kind[ch] == EDGE_RISE) begin
                    evt_count++;
                    rise_count++;
                end else begin
                    check_value("o_event.kind", 32'(EDGE_FALL), 32'(o_event.kind[ch]));
                    evt_count++;
                end
            end
        end
    end

    // run limit from the table length
    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles in row %0d", cycle_cnt, cur_row);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h got %h (row %0d)", name, expected, actual, cur_row);
            $display("Something failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic add_row(input logic [CH_NUM-1:0] pins, input int hold, input logic glitch,
                           input logic [CH_NUM-1:0] invert, input logic [CH_NUM-1:0] rise_en,
                           input logic [CH_NUM-1:0] fall_en, input logic clr,
                           input logic [CH_NUM-1:0] clr_mask);
        row_t r;
        r          = '0;
        r.pins     = pins;
        r.hold     = 8'(hold);
        r.glitch   = glitch;
        r.invert   = invert;
        r.rise_en  = rise_en;
        r.fall_en  = fall_en;
        r.clr      = clr;
        r.clr_mask = clr_mask;
        rows.push_back(r);
    endtask

    // ==================================================
    // stimulus table
    // ==================================================

    // step rows hold enough samples for a change to settle
    // glitch rows flip random channels for 1..UP_TH samples
    task automatic build_table();
        add_row(8'h00, 8, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h00, 1, 1'b1, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h00, 6, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h00, 2, 1'b1, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h00, 6, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h00, 3, 1'b1, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h00, 6, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        // accepted steps raise rising events
        add_row(8'hA5, 8, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'hA5, 2, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b1, 8'h05);
        // falls on 5 and 7 are disabled
        add_row(8'h0F, 8, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h00, 3, 1'b1, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h0F, 6, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        // invert with steady pins
        add_row(8'h0F, 2, 1'b0, 8'h30, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h0F, 2, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b0, 8'h00);
        add_row(8'h0F, 2, 1'b0, 8'h00, 8'hFF, 8'h0F, 1'b1, 8'hFF);
        // falling events only
        add_row(8'h00, 8, 1'b0, 8'h00, 8'h00, 8'hFF, 1'b0, 8'h00);
        add_row(8'hF0, 8, 1'b0, 8'h00, 8'h00, 8'hFF, 1'b0, 8'h00);
        // masked clears drop irq on the last one
        add_row(8'hF0, 2, 1'b0, 8'h00, 8'h00, 8'hFF, 1'b1, 8'h03);
        add_row(8'hF0, 2, 1'b0, 8'h00, 8'h00, 8'hFF, 1'b1, 8'h0C);
        add_row(8'h00, 2, 1'b1, 8'h00, 8'h00, 8'hFF, 1'b0, 8'h00);
        add_row(8'hF0, 6, 1'b0, 8'h00, 8'h00, 8'hFF, 1'b0, 8'h00);
    endtask

    // ==================================================
    // reference model
    // ==================================================

    // one sample strobe through the persistence rule
    task automatic model_sample(input logic [CH_NUM-1:0] pins);
        for (int ch = 0; ch < CH_NUM; ch++) begin
            if (m_have) begin
                if (pins[ch] != m_last[ch]) begin
                    m_qual[ch] = 1'b1;
                    m_cnt[ch]  = 1;
                end else if (m_qual[ch] && m_cnt[ch] >= UP_TH) begin
                    m_filt[ch] = pins[ch];
                    m_qual[ch] = 1'b0;
                    m_cnt[ch]  = 0;
                end else if (m_qual[ch]) begin
                    m_cnt[ch]++;
                end
            end
        end
        // first sample only sets the comparison value
        m_last = pins;
        m_have = 1'b1;
    endtask

    // fills the expected columns and the run limit
    task automatic predict_rows();
        logic [CH_NUM-1:0] prev_pins;
        logic [CH_NUM-1:0] prev_level;
        logic [CH_NUM-1:0] level;
        logic [CH_NUM-1:0] rise_hits;
        logic [CH_NUM-1:0] hits;
        logic [CH_NUM-1:0] pending;
        int unsigned       events;
        int unsigned       rises;
        int unsigned       total;
        prev_pins  = '0;
        prev_level = '0;
        pending    = '0;
        events     = 0;
        rises      = 0;
        total      = 0;
        m_last     = '0;
        m_filt     = '0;
        m_qual     = '0;
        m_have     = 1'b0;
        foreach (m_cnt[ch]) m_cnt[ch] = 0;
        foreach (rows[i]) begin
            if (rows[i].glitch) begin
                rows[i].pins = prev_pins ^ CH_NUM'($urandom_range(255, 1));
            end
            // clear lands before any edge of the same row
            if (rows[i].clr) begin
                pending &= ~rows[i].clr_mask;
            end
            for (int s = 0; s < rows[i].hold; s++) begin
                model_sample(rows[i].pins);
            end
            level     = m_filt ^ rows[i].invert;
            rise_hits = level & ~prev_level & rows[i].rise_en;
            hits      = rise_hits | (~level & prev_level & rows[i].fall_en);
            pending |= hits;
            events  += $countones(hits);
            rises   += $countones(rise_hits);
            rows[i].exp_level   = level;
            rows[i].exp_pending = pending;
            rows[i].exp_irq     = |pending;
            rows[i].exp_events  = 16'(events);
            rows[i].exp_rises   = 16'(rises);
            prev_level = level;
            prev_pins  = rows[i].pins;
            total     += rows[i].hold;
        end
        cycle_limit = RESET_CYCLES + total * SAMPLE_DIV + MARGIN_CYCLES;
    endtask

    // ==================================================
    // row driver
    // ==================================================

    // a row spans hold sample periods and is checked at its end
    task automatic apply_row(input int idx);
        cur_row         = idx;
        i_pins          = rows[idx].pins;
        i_cfg.invert    = rows[idx].invert;
        i_cfg.rise_en   = rows[idx].rise_en;
        i_cfg.fall_en   = rows[idx].fall_en;
        i_clr           = rows[idx].clr;
        i_clr_mask      = rows[idx].clr_mask;
        @(posedge i_clk);
        #2;
        i_clr = 1'b0;
        repeat (rows[idx].hold * SAMPLE_DIV - 1) @(posedge i_clk);
        #1;
        check_value("o_level", 32'(rows[idx].exp_level), 32'(o_level));
        check_value("o_pending", 32'(rows[idx].exp_pending), 32'(o_pending));
        check_value("o_irq", 32'(rows[idx].exp_irq), 32'(o_irq));
        check_value("o_event.hit", 32'h0, 32'(o_event.hit));
        check_value("event_count", 32'(rows[idx].exp_events), 32'(evt_count));
        check_value("rise_count", 32'(rows[idx].exp_rises), 32'(rise_count));
        #1;
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_pins     = '0;
        i_cfg      = '0;
        i_clr      = 1'b0;
        i_clr_mask = '0;
        void'($urandom(69));
        build_table();
        predict_rows();
        repeat (RESET_CYCLES) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        check_value("o_level", 32'h0, 32'(o_level));
        check_value("o_event", 32'h0, 32'(o_event));
        check_value("o_pending", 32'h0, 32'(o_pending));
        check_value("o_irq", 32'h0, 32'(o_irq));
        foreach (rows[i]) begin
            apply_row(i);
        end
        $display("Everything OK");
        $finish;
    end

endmodule : tb_gpio_deglitch
